// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_decode_stage
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
SIM_FLAGS ?= +verilator+error+limit+100

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR, TOP, FLIST, BUILD_DIR, VFLAGS, SIM_FLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_FLAGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf $(BUILD_DIR)

// File: flist.f
+incdir+source
source/decode_pkg.sv
source/cir_control.sv
source/instr_decoder.sv
source/decode_stage.sv
verif/decode_assertions.sv
verif/tb_clock_gen.sv
verif/tb_decode_stage.sv

// File: source/cir_control.sv
`timescale 1ns/1ns
`default_nettype none

`include "decode_cfg.svh"

module cir_control import decode_pkg::*; (
	input  wire         clk,
	input  wire         rst_n,

	input  wire         cir_vld_i,
	input  wire         x_stall_i,
	input  wire         jump_now_i,
	input  wire         jump_not_except_i,
	input  wire addr_t  jump_target_i,

	output logic        cir_use_o,
	output logic        cir_flush_behind_o,
	output logic        starved_o,
	output logic        lock_active_o,
	output addr_t       pc_o
);

	logic  stall;
	logic  assert_lock;
	logic  lock;
	logic  lock_prev;
	addr_t lock_target;
	addr_t pc;

	// --------------------------------------------------
	// Stall and consume

	assign starved_o = !cir_vld_i;
	assign stall     = x_stall_i || starved_o;
	assign cir_use_o = !stall;

	// --------------------------------------------------
	// CIR lock

	// A jump raised by the instruction in decode can't be held back while
	// decode is stalled, so the frontend keeps this instruction and refetches
	// behind it. The instruction finishes once the stall clears
	assign assert_lock = jump_now_i && jump_not_except_i && stall;
	assign lock        = (lock_prev && stall) || assert_lock;

	// Only the first locked cycle tells the frontend to flush behind the CIR
	assign cir_flush_behind_o = assert_lock && !lock_prev;
	assign lock_active_o      = lock_prev;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			lock_prev <= 1'b0;
		end else begin
			lock_prev <= lock;
		end
	end

	// Target is kept here so the frontend may drop it after the jump
	always_ff @(posedge clk) begin
		if (assert_lock) begin
			lock_target <= jump_target_i;
		end
	end

	// --------------------------------------------------
	// Program counter

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= `DEC_RESET_VECTOR;
		end else if (jump_now_i && !assert_lock) begin
			pc <= jump_target_i;
		end else if (lock_prev && !stall) begin
			// Lock releases in this cycle
			pc <= lock_target;
		end else if (!stall && !lock) begin
			pc <= pc + addr_t'(`DEC_INSTR_STEP);
		end
	end

	assign pc_o = pc;

endmodule

`default_nettype wire

// File: source/decode_cfg.svh
`ifndef DECODE_CFG_SVH
`define DECODE_CFG_SVH

// --------------------------------------------------
// Datapath widths

// Data and address width of the core
`define DEC_XLEN 32

// Register file address width, 32 integer registers
`define DEC_REGADDR_W 5

// --------------------------------------------------
// Program counter

// First instruction fetched after reset
`define DEC_RESET_VECTOR 32'h0000_0040

// Only 32-bit instructions exist, so the PC always moves by one word
`define DEC_INSTR_STEP 4

`endif

// File: source/decode_pkg.sv
`default_nettype none

`include "decode_cfg.svh"

package decode_pkg;

	// --------------------------------------------------
	// Plain vectors with a meaning

	typedef logic [`DEC_XLEN-1:0]      addr_t;
	typedef logic [`DEC_XLEN-1:0]      data_t;
	typedef logic [`DEC_XLEN-1:0]      instr_t;
	typedef logic [`DEC_REGADDR_W-1:0] regaddr_t;

	// --------------------------------------------------
	// Control encodings handed to execute

	typedef enum logic {
		ALUSRCA_RS1,
		ALUSRCA_PC
	} alusrc_a_e;

	typedef enum logic {
		ALUSRCB_RS2,
		ALUSRCB_IMM
	} alusrc_b_e;

	// RS2 passes operand B straight through, used for LUI and store data
	typedef enum logic [3:0] {
		ALUOP_ADD,
		ALUOP_SUB,
		ALUOP_LT,
		ALUOP_LTU,
		ALUOP_AND,
		ALUOP_OR,
		ALUOP_XOR,
		ALUOP_SLL,
		ALUOP_SRL,
		ALUOP_SRA,
		ALUOP_RS2
	} aluop_e;

	typedef enum logic [3:0] {
		MEMOP_NONE,
		MEMOP_LB,
		MEMOP_LH,
		MEMOP_LW,
		MEMOP_LBU,
		MEMOP_LHU,
		MEMOP_SB,
		MEMOP_SH,
		MEMOP_SW
	} memop_e;

	// ZERO and NZERO test the ALU result, so BGE is LT with ZERO
	typedef enum logic [1:0] {
		BCOND_NEVER,
		BCOND_ZERO,
		BCOND_NZERO,
		BCOND_ALWAYS
	} bcond_e;

	typedef enum logic [2:0] {
		EXCEPT_NONE,
		EXCEPT_INSTR_FAULT,
		EXCEPT_INSTR_ILLEGAL,
		EXCEPT_ECALL_M,
		EXCEPT_EBREAK,
		EXCEPT_MRET
	} except_e;

endpackage

`default_nettype wire

// File: source/decode_stage.sv
`timescale 1ns/1ns
`default_nettype none

module decode_stage import decode_pkg::*; (
	input  wire            clk,
	input  wire            rst_n,

	// Fetch side
	input  wire instr_t    cir_i,
	input  wire            cir_vld_i,
	input  wire            cir_err_i,
	output wire            cir_use_o,
	output wire            cir_flush_behind_o,
	output wire            starved_o,
	output wire            lock_active_o,
	output wire addr_t     pc_o,

	// Execute side
	input  wire            m_mode_i,
	input  wire            x_stall_i,
	input  wire            jump_now_i,
	input  wire            jump_not_except_i,
	input  wire addr_t     jump_target_i,

	// Decoded controls
	output wire regaddr_t  rs1_o,
	output wire regaddr_t  rs2_o,
	output wire regaddr_t  rd_o,
	output wire data_t     imm_o,
	output wire alusrc_a_e alusrc_a_o,
	output wire alusrc_b_e alusrc_b_o,
	output wire aluop_e    aluop_o,
	output wire memop_e    memop_o,
	output wire bcond_e    branchcond_o,
	output wire addr_t     addr_offs_o,
	output wire            addr_is_regoffs_o,
	output wire except_e   except_o
);

	// PC and CIR handshake
	cir_control u_cir_control (
		.clk                (clk),
		.rst_n              (rst_n),
		.cir_vld_i          (cir_vld_i),
		.x_stall_i          (x_stall_i),
		.jump_now_i         (jump_now_i),
		.jump_not_except_i  (jump_not_except_i),
		.jump_target_i      (jump_target_i),
		.cir_use_o          (cir_use_o),
		.cir_flush_behind_o (cir_flush_behind_o),
		.starved_o          (starved_o),
		.lock_active_o      (lock_active_o),
		.pc_o               (pc_o)
	);

	// Combinational decode of the current instruction
	instr_decoder u_instr_decoder (
		.cir_i             (cir_i),
		.cir_err_i         (cir_err_i),
		.starved_i         (starved_o),
		.lock_active_i     (lock_active_o),
		.m_mode_i          (m_mode_i),
		.rs1_o             (rs1_o),
		.rs2_o             (rs2_o),
		.rd_o              (rd_o),
		.imm_o             (imm_o),
		.alusrc_a_o        (alusrc_a_o),
		.alusrc_b_o        (alusrc_b_o),
		.aluop_o           (aluop_o),
		.memop_o           (memop_o),
		.branchcond_o      (branchcond_o),
		.addr_offs_o       (addr_offs_o),
		.addr_is_regoffs_o (addr_is_regoffs_o),
		.except_o          (except_o)
	);

endmodule

`default_nettype wire

// File: source/instr_decoder.sv
`timescale 1ns/1ns
`default_nettype none

`include "decode_cfg.svh"

module instr_decoder import decode_pkg::*; (
	input  wire instr_t cir_i,
	input  wire         cir_err_i,
	input  wire         starved_i,
	input  wire         lock_active_i,
	input  wire         m_mode_i,

	output regaddr_t    rs1_o,
	output regaddr_t    rs2_o,
	output regaddr_t    rd_o,
	output data_t       imm_o,
	output alusrc_a_e   alusrc_a_o,
	output alusrc_b_e   alusrc_b_o,
	output aluop_e      aluop_o,
	output memop_e      memop_o,
	output bcond_e      branchcond_o,
	output addr_t       addr_offs_o,
	output logic        addr_is_regoffs_o,
	output except_e     except_o
);

	localparam logic [6:0] OPC_LOAD     = 7'b0000011;
	localparam logic [6:0] OPC_MISC_MEM = 7'b0001111;
	localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
	localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
	localparam logic [6:0] OPC_STORE    = 7'b0100011;
	localparam logic [6:0] OPC_OP       = 7'b0110011;
	localparam logic [6:0] OPC_LUI      = 7'b0110111;
	localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
	localparam logic [6:0] OPC_JALR     = 7'b1100111;
	localparam logic [6:0] OPC_JAL      = 7'b1101111;
	localparam logic [6:0] OPC_SYSTEM   = 7'b1110011;

	// SYSTEM instructions are matched on the whole word
	localparam instr_t INSTR_ECALL  = 32'h0000_0073;
	localparam instr_t INSTR_EBREAK = 32'h0010_0073;
	localparam instr_t INSTR_MRET   = 32'h3020_0073;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	data_t      imm_i;
	data_t      imm_s;
	data_t      imm_b;
	data_t      imm_u;
	data_t      imm_j;
	logic       invalid;

	assign opcode = cir_i[6:0];
	assign funct3 = cir_i[14:12];
	assign funct7 = cir_i[31:25];

	// --------------------------------------------------
	// Immediate formats

	assign imm_i = {{20{cir_i[31]}}, cir_i[31:20]};
	assign imm_s = {{20{cir_i[31]}}, cir_i[31:25], cir_i[11:7]};
	assign imm_b = {{20{cir_i[31]}}, cir_i[7], cir_i[30:25], cir_i[11:8], 1'b0};
	assign imm_u = {cir_i[31:12], 12'h000};
	assign imm_j = {{12{cir_i[31]}}, cir_i[19:12], cir_i[20], cir_i[30:21], 1'b0};

	// --------------------------------------------------
	// Opcode decode and squashing

	always_comb begin
		rs1_o             = cir_i[19:15];
		rs2_o             = cir_i[24:20];
		rd_o              = cir_i[11:7];
		imm_o             = imm_i;
		alusrc_a_o        = ALUSRCA_RS1;
		alusrc_b_o        = ALUSRCB_RS2;
		aluop_o           = ALUOP_ADD;
		memop_o           = MEMOP_NONE;
		branchcond_o      = BCOND_NEVER;
		addr_offs_o       = '0;
		addr_is_regoffs_o = 1'b0;
		except_o          = EXCEPT_NONE;
		invalid           = 1'b0;

		case (opcode)
			OPC_LUI: begin
				rs1_o      = '0;
				rs2_o      = '0;
				imm_o      = imm_u;
				alusrc_b_o = ALUSRCB_IMM;
				aluop_o    = ALUOP_RS2;
			end
			OPC_AUIPC: begin
				rs1_o      = '0;
				rs2_o      = '0;
				imm_o      = imm_u;
				alusrc_a_o = ALUSRCA_PC;
				alusrc_b_o = ALUSRCB_IMM;
			end
			OPC_JAL, OPC_JALR: begin
				// Link value PC+4 goes through the ALU, the target adder uses addr_offs
				rs2_o        = '0;
				imm_o        = data_t'(`DEC_INSTR_STEP);
				alusrc_a_o   = ALUSRCA_PC;
				alusrc_b_o   = ALUSRCB_IMM;
				branchcond_o = BCOND_ALWAYS;
				if (opcode == OPC_JAL) begin
					rs1_o       = '0;
					addr_offs_o = imm_j;
				end else begin
					invalid           = funct3 != 3'b000;
					addr_is_regoffs_o = 1'b1;
					addr_offs_o       = imm_i;
				end
			end
			OPC_BRANCH: begin
				rd_o        = '0;
				addr_offs_o = imm_b;
				case (funct3)
					3'b000:  begin aluop_o = ALUOP_SUB; branchcond_o = BCOND_ZERO;  end
					3'b001:  begin aluop_o = ALUOP_SUB; branchcond_o = BCOND_NZERO; end
					3'b100:  begin aluop_o = ALUOP_LT;  branchcond_o = BCOND_NZERO; end
					3'b101:  begin aluop_o = ALUOP_LT;  branchcond_o = BCOND_ZERO;  end
					3'b110:  begin aluop_o = ALUOP_LTU; branchcond_o = BCOND_NZERO; end
					3'b111:  begin aluop_o = ALUOP_LTU; branchcond_o = BCOND_ZERO;  end
					default: invalid = 1'b1;
				endcase
			end
			OPC_LOAD: begin
				rs2_o             = '0;
				addr_is_regoffs_o = 1'b1;
				addr_offs_o       = imm_i;
				case (funct3)
					3'b000:  memop_o = MEMOP_LB;
					3'b001:  memop_o = MEMOP_LH;
					3'b010:  memop_o = MEMOP_LW;
					3'b100:  memop_o = MEMOP_LBU;
					3'b101:  memop_o = MEMOP_LHU;
					default: invalid = 1'b1;
				endcase
			end
			OPC_STORE: begin
				rd_o              = '0;
				aluop_o           = ALUOP_RS2;
				addr_is_regoffs_o = 1'b1;
				addr_offs_o       = imm_s;
				case (funct3)
					3'b000:  memop_o = MEMOP_SB;
					3'b001:  memop_o = MEMOP_SH;
					3'b010:  memop_o = MEMOP_SW;
					default: invalid = 1'b1;
				endcase
			end
			OPC_OP_IMM: begin
				rs2_o      = '0;
				alusrc_b_o = ALUSRCB_IMM;
				case (funct3)
					3'b000: aluop_o = ALUOP_ADD;
					3'b010: aluop_o = ALUOP_LT;
					3'b011: aluop_o = ALUOP_LTU;
					3'b100: aluop_o = ALUOP_XOR;
					3'b110: aluop_o = ALUOP_OR;
					3'b111: aluop_o = ALUOP_AND;
					3'b001: begin
						aluop_o = ALUOP_SLL;
						invalid = funct7 != 7'b0000000;
					end
					default: begin
						// Shift right, funct7 picks logical or arithmetic
						aluop_o = funct7[5] ? ALUOP_SRA : ALUOP_SRL;
						invalid = {funct7[6], funct7[4:0]} != 6'b000000;
					end
				endcase
			end
			OPC_OP: begin
				case ({funct7, funct3})
					10'b0000000_000: aluop_o = ALUOP_ADD;
					10'b0100000_000: aluop_o = ALUOP_SUB;
					10'b0000000_001: aluop_o = ALUOP_SLL;
					10'b0000000_010: aluop_o = ALUOP_LT;
					10'b0000000_011: aluop_o = ALUOP_LTU;
					10'b0000000_100: aluop_o = ALUOP_XOR;
					10'b0000000_101: aluop_o = ALUOP_SRL;
					10'b0100000_101: aluop_o = ALUOP_SRA;
					10'b0000000_110: aluop_o = ALUOP_OR;
					10'b0000000_111: aluop_o = ALUOP_AND;
					default:         invalid = 1'b1;
				endcase
			end
			OPC_MISC_MEM: begin
				// FENCE acts as a NOP, rd, rs1 and funct3 must be zero
				rs2_o   = '0;
				invalid = cir_i[19:7] != 13'h0000;
			end
			OPC_SYSTEM: begin
				rs1_o = '0;
				rs2_o = '0;
				rd_o  = '0;
				if (cir_i == INSTR_ECALL) begin
					except_o = EXCEPT_ECALL_M;
				end else if (cir_i == INSTR_EBREAK) begin
					except_o = EXCEPT_EBREAK;
				end else if (cir_i == INSTR_MRET && m_mode_i) begin
					except_o = EXCEPT_MRET;
				end else begin
					invalid = 1'b1;
				end
			end
			default: invalid = 1'b1;
		endcase

		// A slot with nothing to execute must not touch registers, memory or PC
		if (invalid || cir_err_i || starved_i) begin
			rs1_o        = '0;
			rs2_o        = '0;
			rd_o         = '0;
			memop_o      = MEMOP_NONE;
			branchcond_o = BCOND_NEVER;
			aluop_o      = ALUOP_ADD;
			if (cir_err_i && !starved_i) begin
				except_o = EXCEPT_INSTR_FAULT;
			end else if (invalid && !starved_i) begin
				except_o = EXCEPT_INSTR_ILLEGAL;
			end else begin
				except_o = EXCEPT_NONE;
			end
		end

		// The locked instruction has already jumped, so it must not branch again
		if (lock_active_i) begin
			branchcond_o = BCOND_NEVER;
		end
	end

endmodule

`default_nettype wire

// File: verif/decode_assertions.sv
`timescale 1ns/1ns
`default_nettype none

module decode_assertions import decode_pkg::*; (
	input wire          clk,
	input wire          rst_n,
	input wire          cir_use_i,
	input wire          starved_i,
	input wire          cir_flush_behind_i,
	input wire          x_stall_i,
	input wire          jump_now_i,
	input wire addr_t   pc_i,
	input wire except_e except_i
);

	// Read by the testbench top to notice a failed property
	int unsigned fail_count = 0;

	// An empty slot can never be consumed
	a_no_use_when_starved: assert property (
		@(posedge clk) disable iff (!rst_n) !(cir_use_i && starved_i)
	) else begin
		fail_count++;
		$error("cir_use_o is high while starved_o is high");
	end

	a_flush_single_cycle: assert property (
		@(posedge clk) disable iff (!rst_n) cir_flush_behind_i |=> !cir_flush_behind_i
	) else begin
		fail_count++;
		$error("cir_flush_behind_o is high for two cycles");
	end

	// A stalled cycle without a redirect keeps the PC
	a_pc_holds_on_stall: assert property (
		@(posedge clk) disable iff (!rst_n)
		((x_stall_i || starved_i) && !jump_now_i) |=> $stable(pc_i)
	) else begin
		fail_count++;
		$error("pc_o changed across a stalled cycle without a jump");
	end

	a_no_except_when_starved: assert property (
		@(posedge clk) disable iff (!rst_n) starved_i |-> (except_i == EXCEPT_NONE)
	) else begin
		fail_count++;
		$error("except_o is not NONE in a starved slot");
	end

endmodule

`default_nettype wire

// File: verif/tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
	output logic clk_o,
	output logic rst_n_o
);

	localparam int HALF_PERIOD  = 4;
	localparam int RESET_CYCLES = 10;

	initial begin
		clk_o = 1'b0;
		forever #HALF_PERIOD clk_o = ~clk_o;
	end

	// Reset leaves on a falling edge, away from the sampling edge
	initial begin
		rst_n_o = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_o);
		@(negedge clk_o);
		rst_n_o = 1'b1;
	end

endmodule

`default_nettype wire

// File: verif/tb_decode_stage.sv
`timescale 1ns/1ns
`default_nettype none

`include "decode_cfg.svh"

module tb_decode_stage import decode_pkg::*; ();

	localparam int          NUM_CYCLES     = 4000;
	localparam int          RESET_CYCLES   = 10;
	localparam int          TIMEOUT_CYCLES = (RESET_CYCLES + NUM_CYCLES) * 12 / 10;
	localparam logic [31:0] SEED           = 32'hb53f_c95b;

	logic      clk;
	logic      rst_n;

	// DUT inputs
	instr_t    cir;
	logic      cir_vld;
	logic      cir_err;
	logic      m_mode;
	logic      x_stall;
	logic      jump_now;
	logic      jump_not_except;
	addr_t     jump_target;

	// DUT outputs
	logic      cir_use;
	logic      cir_flush_behind;
	logic      starved;
	logic      lock_active;
	addr_t     pc;
	regaddr_t  rs1;
	regaddr_t  rs2;
	regaddr_t  rd;
	data_t     imm;
	alusrc_a_e alusrc_a;
	alusrc_b_e alusrc_b;
	aluop_e    aluop;
	memop_e    memop;
	bcond_e    branchcond;
	addr_t     addr_offs;
	logic      addr_is_regoffs;
	except_e   exc;

	// Expected values from the model
	regaddr_t  exp_rs1;
	regaddr_t  exp_rs2;
	regaddr_t  exp_rd;
	data_t     exp_imm;
	alusrc_a_e exp_alusrc_a;
	alusrc_b_e exp_alusrc_b;
	aluop_e    exp_aluop;
	memop_e    exp_memop;
	bcond_e    exp_branchcond;
	addr_t     exp_addr_offs;
	logic      exp_addr_is_regoffs;
	except_e   exp_exc;
	logic      exp_use;
	logic      exp_starved;
	logic      exp_flush;
	logic      exp_lock_active;
	addr_t     exp_pc;

	// Model state
	logic [31:0] rng;
	logic        mdl_lock;
	addr_t       mdl_lock_target;
	logic        take_lock;
	logic        cur_stall;
	int          failures;
	int          lock_events;
	int          cycle_count;

	tb_clock_gen u_clock_gen (
		.clk_o   (clk),
		.rst_n_o (rst_n)
	);

	decode_stage UUT (
		.clk                (clk),
		.rst_n              (rst_n),
		.cir_i              (cir),
		.cir_vld_i          (cir_vld),
		.cir_err_i          (cir_err),
		.cir_use_o          (cir_use),
		.cir_flush_behind_o (cir_flush_behind),
		.starved_o          (starved),
		.lock_active_o      (lock_active),
		.pc_o               (pc),
		.m_mode_i           (m_mode),
		.x_stall_i          (x_stall),
		.jump_now_i         (jump_now),
		.jump_not_except_i  (jump_not_except),
		.jump_target_i      (jump_target),
		.rs1_o              (rs1),
		.rs2_o              (rs2),
		.rd_o               (rd),
		.imm_o              (imm),
		.alusrc_a_o         (alusrc_a),
		.alusrc_b_o         (alusrc_b),
		.aluop_o            (aluop),
		.memop_o            (memop),
		.branchcond_o       (branchcond),
		.addr_offs_o        (addr_offs),
		.addr_is_regoffs_o  (addr_is_regoffs),
		.except_o           (exc)
	);

	bind decode_stage decode_assertions u_decode_assertions (
		.clk                (clk),
		.rst_n              (rst_n),
		.cir_use_i          (cir_use_o),
		.starved_i          (starved_o),
		.cir_flush_behind_i (cir_flush_behind_o),
		.x_stall_i          (x_stall_i),
		.jump_now_i         (jump_now_i),
		.pc_i               (pc_o),
		.except_i           (except_o)
	);

	// --------------------------------------------------
	// Random numbers and instruction templates

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] s;
		s = x ^ (x << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	task automatic roll(output logic [31:0] v);
		rng = xorshift32(rng);
		v   = rng;
	endtask

	// a supplies the instruction fields, b picks the class and funct3
	function automatic instr_t make_instr(input logic [31:0] a, input logic [31:0] b);
		logic [2:0] f3;
		logic [6:0] f7;
		instr_t     ins;
		f3  = b[6:4];
		f7  = 7'h00;
		ins = a;
		case (b[3:0])
			4'd0: ins = {a[31:7], 7'h37};
			4'd1: ins = {a[31:7], 7'h17};
			4'd2: ins = {a[31:7], 7'h6f};
			4'd3: ins = {a[31:15], 3'b000, a[11:7], 7'h67};
			4'd4: begin
				f3  = b[4] ? {1'b1, b[6:5]} : {2'b00, b[5]};
				ins = {a[31:15], f3, a[11:7], 7'h63};
			end
			4'd5: begin
				f3  = b[4] ? {2'b10, b[5]} : (b[5] ? 3'd2 : {2'b00, b[6]});
				ins = {a[31:15], f3, a[11:7], 7'h03};
			end
			4'd6: begin
				f3  = (b[5:4] == 2'b11) ? 3'd2 : {1'b0, b[5:4]};
				ins = {a[31:15], f3, a[11:7], 7'h23};
			end
			4'd7: begin
				ins = {a[31:15], f3, a[11:7], 7'h13};
				if (f3 == 3'd1) begin
					ins[31:25] = 7'h00;
				end else if (f3 == 3'd5) begin
					ins[31:25] = {1'b0, b[7], 5'b00000};
				end
			end
			4'd8: begin
				if (b[7] && (f3 == 3'd0 || f3 == 3'd5)) begin
					f7 = 7'h20;
				end
				ins = {f7, a[24:15], f3, a[11:7], 7'h33};
			end
			4'd9: ins = {a[31:20], 13'h0000, 7'h0f};
			4'd10: begin
				case (b[5:4])
					2'd0:    ins = 32'h0000_0073;
					2'd1:    ins = 32'h0010_0073;
					default: ins = 32'h3020_0073;
				endcase
			end
			4'd11, 4'd12: begin
				// Encodings outside the kept subset
				case (b[5:4])
					2'd0:    ins = {a[31:7], 7'h0b};
					2'd1:    ins = {a[31:15], 2'b01, b[6], a[11:7], 7'h63};
					2'd2:    ins = {7'h01, a[24:7], 7'h33};
					default: ins = {a[31:15], 3'b001, a[11:7], 7'h73};
				endcase
			end
			default: ins = a;
		endcase
		return ins;
	endfunction

	// Fetch holds a slot that was valid but not consumed
	task automatic drive_random_inputs();
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		logic [31:0] t;
		roll(a);
		roll(b);
		roll(c);
		roll(t);
		if (!(cir_vld && x_stall)) begin
			cir     = make_instr(a, b);
			cir_vld = c[2:0] != 3'b000;
			cir_err = c[7:3] == 5'b00000;
		end
		x_stall         = c[9:8] == 2'b00;
		jump_now        = c[12:10] == 3'b000;
		jump_not_except = c[13];
		m_mode          = c[15:14] != 2'b00;
		jump_target     = {t[31:2], 2'b00};
	endtask

	// --------------------------------------------------
	// Reference model

	function automatic aluop_e alu_for_funct3(input logic [2:0] f3, input logic alt);
		case (f3)
			3'd0:    return alt ? ALUOP_SUB : ALUOP_ADD;
			3'd1:    return ALUOP_SLL;
			3'd2:    return ALUOP_LT;
			3'd3:    return ALUOP_LTU;
			3'd4:    return ALUOP_XOR;
			3'd5:    return alt ? ALUOP_SRA : ALUOP_SRL;
			3'd6:    return ALUOP_OR;
			default: return ALUOP_AND;
		endcase
	endfunction

	task automatic predict_decode(input instr_t ins, input logic err, input logic empty,
		input logic locked, input logic mmode);
		logic [2:0] f3;
		logic [6:0] f7;
		data_t      immi;
		data_t      imms;
		data_t      immb;
		data_t      immu;
		data_t      immj;
		logic       bad;
		f3   = ins[14:12];
		f7   = ins[31:25];
		immi = $signed(ins) >>> 20;
		imms = {immi[31:5], ins[11:7]};
		immb = {immi[31:12], ins[7], ins[30:25], ins[11:8], 1'b0};
		immu = ins & 32'hffff_f000;
		immj = {immi[31:20], ins[19:12], ins[20], ins[30:21], 1'b0};
		bad  = 1'b0;

		exp_rs1             = ins[19:15];
		exp_rs2             = ins[24:20];
		exp_rd              = ins[11:7];
		exp_imm             = immi;
		exp_alusrc_a        = ALUSRCA_RS1;
		exp_alusrc_b        = ALUSRCB_RS2;
		exp_aluop           = ALUOP_ADD;
		exp_memop           = MEMOP_NONE;
		exp_branchcond      = BCOND_NEVER;
		exp_addr_offs       = '0;
		exp_addr_is_regoffs = 1'b0;
		exp_exc             = EXCEPT_NONE;

		case (ins[6:0])
			7'h37, 7'h17: begin
				exp_rs1      = '0;
				exp_rs2      = '0;
				exp_imm      = immu;
				exp_alusrc_b = ALUSRCB_IMM;
				if (ins[5]) begin
					exp_aluop = ALUOP_RS2;
				end else begin
					exp_alusrc_a = ALUSRCA_PC;
				end
			end
			7'h6f, 7'h67: begin
				// Link address PC+4 comes out of the ALU
				exp_rs2        = '0;
				exp_imm        = 32'd4;
				exp_alusrc_a   = ALUSRCA_PC;
				exp_alusrc_b   = ALUSRCB_IMM;
				exp_branchcond = BCOND_ALWAYS;
				if (ins[3]) begin
					exp_rs1       = '0;
					exp_addr_offs = immj;
				end else begin
					bad                 = f3 != 3'd0;
					exp_addr_is_regoffs = 1'b1;
					exp_addr_offs       = immi;
				end
			end
			7'h63: begin
				exp_rd         = '0;
				exp_addr_offs  = immb;
				bad            = f3[2:1] == 2'b01;
				exp_aluop      = !f3[2] ? ALUOP_SUB : (f3[1] ? ALUOP_LTU : ALUOP_LT);
				exp_branchcond = (f3[0] ^ f3[2]) ? BCOND_NZERO : BCOND_ZERO;
			end
			7'h03: begin
				exp_rs2             = '0;
				exp_addr_is_regoffs = 1'b1;
				exp_addr_offs       = immi;
				case (f3)
					3'd0:    exp_memop = MEMOP_LB;
					3'd1:    exp_memop = MEMOP_LH;
					3'd2:    exp_memop = MEMOP_LW;
					3'd4:    exp_memop = MEMOP_LBU;
					3'd5:    exp_memop = MEMOP_LHU;
					default: bad = 1'b1;
				endcase
			end
			7'h23: begin
				exp_rd              = '0;
				exp_aluop           = ALUOP_RS2;
				exp_addr_is_regoffs = 1'b1;
				exp_addr_offs       = imms;
				case (f3)
					3'd0:    exp_memop = MEMOP_SB;
					3'd1:    exp_memop = MEMOP_SH;
					3'd2:    exp_memop = MEMOP_SW;
					default: bad = 1'b1;
				endcase
			end
			7'h13: begin
				exp_rs2      = '0;
				exp_alusrc_b = ALUSRCB_IMM;
				exp_aluop    = alu_for_funct3(f3, f3 == 3'd5 && f7 == 7'h20);
				bad          = (f3 == 3'd1 && f7 != 7'h00) ||
					(f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20);
			end
			7'h33: begin
				exp_aluop = alu_for_funct3(f3, f7 == 7'h20);
				bad       = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
			end
			7'h0f: begin
				exp_rs2 = '0;
				bad     = ins[19:7] != 13'h0000;
			end
			7'h73: begin
				exp_rs1 = '0;
				exp_rs2 = '0;
				exp_rd  = '0;
				case (ins)
					32'h0000_0073: exp_exc = EXCEPT_ECALL_M;
					32'h0010_0073: exp_exc = EXCEPT_EBREAK;
					32'h3020_0073: begin
						if (mmode) begin
							exp_exc = EXCEPT_MRET;
						end else begin
							bad = 1'b1;
						end
					end
					default: bad = 1'b1;
				endcase
			end
			default: bad = 1'b1;
		endcase

		if (bad || err || empty) begin
			exp_rs1        = '0;
			exp_rs2        = '0;
			exp_rd         = '0;
			exp_memop      = MEMOP_NONE;
			exp_branchcond = BCOND_NEVER;
			exp_aluop      = ALUOP_ADD;
			if (empty) begin
				exp_exc = EXCEPT_NONE;
			end else if (err) begin
				exp_exc = EXCEPT_INSTR_FAULT;
			end else begin
				exp_exc = EXCEPT_INSTR_ILLEGAL;
			end
		end
		if (locked) begin
			exp_branchcond = BCOND_NEVER;
		end
	endtask

	task automatic predict_control();
		cur_stall       = x_stall || !cir_vld;
		take_lock       = jump_now && jump_not_except && cur_stall;
		exp_starved     = !cir_vld;
		exp_use         = !cur_stall;
		exp_flush       = take_lock && !mdl_lock;
		exp_lock_active = mdl_lock;
	endtask

	// State change at the coming rising edge
	task automatic advance_model();
		if (jump_now && !take_lock) begin
			exp_pc = jump_target;
		end else if (mdl_lock && !cur_stall) begin
			exp_pc = mdl_lock_target;
		end else if (!cur_stall) begin
			exp_pc = exp_pc + `DEC_INSTR_STEP;
		end
		if (take_lock) begin
			mdl_lock_target = jump_target;
			lock_events++;
		end
		mdl_lock = take_lock || (mdl_lock && cur_stall);
	endtask

	// --------------------------------------------------
	// Compare tasks

	task stop_on_failure();
		failures++;
		$display("TESTBENCH FAILED");
		$fatal(1, "Stopped at the first failure");
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
			stop_on_failure();
		end
	endtask

	task automatic check_addr(input string name, input addr_t got, input addr_t exp);
		if (got !== exp) begin
			$display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
			stop_on_failure();
		end
	endtask

	task automatic check_data(input string name, input data_t got, input data_t exp);
		if (got !== exp) begin
			$display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
			stop_on_failure();
		end
	endtask

	task automatic check_reg(input string name, input regaddr_t got, input regaddr_t exp);
		if (got !== exp) begin
			$display("[ERROR] %s: got 0x%02h, expected 0x%02h", name, got, exp);
			stop_on_failure();
		end
	endtask

	task automatic check_srca(input string name, input alusrc_a_e got, input alusrc_a_e exp);
		if (got !== exp) begin
			$display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
			stop_on_failure();
		end
	endtask

	task automatic check_srcb(input string name, input alusrc_b_e got, input alusrc_b_e exp);
		if (got !== exp) begin
			$display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
			stop_on_failure();
		end
	endtask

	task automatic check_aluop(input string name, input aluop_e got, input aluop_e exp);
		if (got !== exp) begin
			$display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
			stop_on_failure();
		end
	endtask

	task automatic check_memop(input string name, input memop_e got, input memop_e exp);
		if (got !== exp) begin
			$display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
			stop_on_failure();
		end
	endtask

	task automatic check_bcond(input string name, input bcond_e got, input bcond_e exp);
		if (got !== exp) begin
			$display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
			stop_on_failure();
		end
	endtask

	task automatic check_except(input string name, input except_e got, input except_e exp);
		if (got !== exp) begin
			$display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
			stop_on_failure();
		end
	endtask

	task automatic compare_outputs();
		if (UUT.u_decode_assertions.fail_count != 0) begin
			$display("A concurrent assertion on the decode stage failed");
			stop_on_failure();
		end
		check_addr("pc_o", pc, exp_pc);
		check_bit("cir_use_o", cir_use, exp_use);
		check_bit("starved_o", starved, exp_starved);
		check_bit("cir_flush_behind_o", cir_flush_behind, exp_flush);
		check_bit("lock_active_o", lock_active, exp_lock_active);
		check_reg("rs1_o", rs1, exp_rs1);
		check_reg("rs2_o", rs2, exp_rs2);
		check_reg("rd_o", rd, exp_rd);
		check_data("imm_o", imm, exp_imm);
		check_srca("alusrc_a_o", alusrc_a, exp_alusrc_a);
		check_srcb("alusrc_b_o", alusrc_b, exp_alusrc_b);
		check_aluop("aluop_o", aluop, exp_aluop);
		check_memop("memop_o", memop, exp_memop);
		check_bcond("branchcond_o", branchcond, exp_branchcond);
		check_addr("addr_offs_o", addr_offs, exp_addr_offs);
		check_bit("addr_is_regoffs_o", addr_is_regoffs, exp_addr_is_regoffs);
		check_except("except_o", exc, exp_exc);
	endtask

	// --------------------------------------------------
	// Run control

	initial begin
		cycle_count = 0;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("TESTBENCH FAILED");
			$fatal(1, "Timeout");
		end
	end

	initial begin
		cir             = '0;
		cir_vld         = 1'b0;
		cir_err         = 1'b0;
		m_mode          = 1'b1;
		x_stall         = 1'b0;
		jump_now        = 1'b0;
		jump_not_except = 1'b0;
		jump_target     = '0;
		rng             = SEED;
		exp_pc          = `DEC_RESET_VECTOR;
		mdl_lock        = 1'b0;
		mdl_lock_target = '0;
		take_lock       = 1'b0;
		cur_stall       = 1'b1;
		failures        = 0;
		lock_events     = 0;

		wait (rst_n === 1'b1);
		for (int i = 0; i < NUM_CYCLES; i++) begin
			@(negedge clk);
			drive_random_inputs();
			// Outputs have settled well before the next rising edge
			#2;
			predict_control();
			predict_decode(cir, cir_err, !cir_vld, mdl_lock, m_mode);
			compare_outputs();
			advance_model();
		end

		if (lock_events == 0) begin
			$display("The random run never asserted the CIR lock");
			failures++;
		end
		if (failures == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
